/* stark_stomp.f */
+incdir+.
stark_pkg.sv
branch_sequencer.sv
fe_stomp.sv
rob_stomp.sv
stark_stomp.sv
stark_stomp_sva.sv
stark_stomp_tb.sv

/* Bender.yml */
package:
  name: stark_stomp

export_include_dirs:
  - .

sources:
  - stark_pkg.sv
  - branch_sequencer.sv
  - fe_stomp.sv
  - rob_stomp.sv
  - stark_stomp.sv
  - target: test
    files:
      - stark_stomp_sva.sv
      - stark_stomp_tb.sv

/* stark_stomp_tb.sv */
// ============================================================
// testbench for the flush subsystem top level
// random stimulus, reference model, per-cycle output compare
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "stark_cfg.svh"

module stark_stomp_tb;

	localparam int N = `STARK_ROB_ENTRIES;
	// the six tests in cycles, the run is cut off at twice their sum
	localparam int LEN_TOTAL = 8 + 80 + 120 + 80 + 80 + 400;
	localparam int CYCLE_LIMIT = 2 * LEN_TOTAL;

	logic clk, rst, advance_pipeline, advance_pipeline_seg2;
	logic branchmiss, found_destination, fcu_idv, takb;
	stark_pkg::rob_ndx_t destination_rndx, missid, fcu_id;
	stark_pkg::pc_address_t misspc, pc, pc_f, pc_fet, pc_mux, pc_dec;
	logic [`STARK_BNO_W-1:0] stomp_bno;
	stark_pkg::rob_array_t rob;
	stark_pkg::branch_state_t branch_state;
	logic stomp_fet, stomp_mux, stomp_dec, stomp_ren;
	logic [N-1:0] robentry_stomp;

	integer seed = 32'h1b16f02c;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_failed = 0;

	// ========================================================
	// reference model state
	// ========================================================

	// recovery step, 0 is idle and 4 the last state before idle
	int m_state;
	logic m_sp_q;
	logic m_start;
	logic [`STARK_PC_W-1:0] m_slot [5];
	// bit 0 is align, which never holds a register and stays clear
	logic [4:0] m_stomp_r;
	logic [N-1:0] m_rob_stomp;

	stark_stomp stark_stomp_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic bit chance(input int pct);
		return (($random(seed) & 32'h7fff_ffff) % 100) < pct;
	endfunction

	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	// addresses come from a small pool so that stage and miss addresses
	// collide often and stages get released
	function automatic stark_pkg::pc_address_t rand_addr();
		stark_pkg::pc_address_t a;
		int r;
		r = rand_below(4);
		a.bno_t = `STARK_BNO_W'(rand_below(32));
		a.bno_f = `STARK_BNO_W'(rand_below(32));
		a.pc = (r == 0) ? `STARK_RSTPC : `STARK_PC_W'(32'h1000 + r * 64);
		return a;
	endfunction

	// now and then a stage shows exactly the address its slot expects
	function automatic stark_pkg::pc_address_t stage_addr(input int i);
		stark_pkg::pc_address_t a;
		a = rand_addr();
		if (chance(25))
			a.pc = m_slot[i];
		return a;
	endfunction

	function automatic logic [`STARK_PC_W-1:0] stage_pc_at(input int i);
		case (i)
			0: return pc.pc;
			1: return pc_f.pc;
			2: return pc_fet.pc;
			3: return pc_mux.pc;
			default: return pc_dec.pc;
		endcase
	endfunction

	// a stage is stomped while marked and not yet showing the corrected address
	function automatic logic [4:0] model_fe();
		logic [4:0] s;
		for (int i = 0; i < 5; i++)
			s[i] = (m_start || m_stomp_r[i]) && stage_pc_at(i) != m_slot[i];
		return s;
	endfunction

	function automatic logic [N-1:0] model_rob();
		logic [N-1:0] b;
		logic active;
		logic exempt;
		active = branchmiss || (m_state >= 1 && m_state <= 3);
		if (`STARK_SUPPORT_BACKOUT)
			exempt = fcu_idv && (rob[fcu_id].br || rob[fcu_id].cjb);
		else
			exempt = fcu_idv && rob[fcu_id].br && !takb;
		for (int n = 0; n < N; n++) begin
			if (found_destination)
				b[n] = rob[n].sn > rob[missid].sn && rob[n].sn < rob[destination_rndx].sn;
			else
				b[n] = active && fcu_idv && rob[n].sn > rob[missid].sn &&
					rob[n].bno_t != stomp_bno;
			// copy targets behind the resolving branch survive
			if (exempt && rob[n].grp == rob[fcu_id].grp && rob[n].sn > rob[fcu_id].sn)
				b[n] = 1'b0;
		end
		return b;
	endfunction

	// one clock edge of the model, using the inputs the DUT samples
	task automatic model_step();
		logic [4:0] s;
		logic lvl;
		logic adv;
		s = model_fe();
		lvl = (branchmiss && !found_destination) || m_state != 0;
		if (rst) begin
			m_state = 0;
			m_sp_q = 1'b0;
			m_start = 1'b0;
			m_stomp_r = 5'b11110;
			m_rob_stomp = '0;
			for (int i = 0; i < 5; i++)
				m_slot[i] = `STARK_RSTPC;
			return;
		end
		m_rob_stomp = model_rob();
		if (m_state != 0)
			m_state = (m_state == 4) ? 0 : m_state + 1;
		else if (branchmiss && !found_destination)
			m_state = 1;
		for (int i = 1; i < 5; i++) begin
			adv = (i == 4) ? advance_pipeline_seg2 : advance_pipeline;
			if (m_start)
				m_stomp_r[i] = 1'b1;
			else if (adv)
				m_stomp_r[i] = s[i-1] && stage_pc_at(i) != m_slot[i];
		end
		if (m_start || advance_pipeline) begin
			for (int i = 4; i > 0; i--)
				m_slot[i] = m_slot[i-1];
		end
		if (m_start)
			m_slot[0] = misspc.pc;
		m_start = advance_pipeline && lvl && !m_sp_q;
		if (advance_pipeline)
			m_sp_q = lvl;
	endtask

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("ERROR %0t: %s is %0h, model expects %0h", $time, what, got, exp);
		end
	endtask

	task automatic compare_outputs();
		logic [4:0] s;
		s = model_fe();
		check("branch_state", branch_state, m_state);
		check("stomp_fet", stomp_fet, s[1]);
		check("stomp_mux", stomp_mux, s[2]);
		check("stomp_dec", stomp_dec, s[3]);
		check("stomp_ren", stomp_ren, s[4]);
		check("robentry_stomp", robentry_stomp, m_rob_stomp);
	endtask

	task automatic drive_inputs(input int p_miss, input int p_fd, input int p_adv, input int p_fcu);
		branchmiss = chance(p_miss);
		found_destination = chance(p_fd);
		advance_pipeline = chance(p_adv);
		advance_pipeline_seg2 = chance(p_adv);
		fcu_idv = chance(p_fcu);
		takb = chance(50);
		missid = stark_pkg::rob_ndx_t'(rand_below(N));
		destination_rndx = stark_pkg::rob_ndx_t'(rand_below(N));
		fcu_id = stark_pkg::rob_ndx_t'(rand_below(N));
		stomp_bno = `STARK_BNO_W'(rand_below(4));
		misspc = rand_addr();
		pc = stage_addr(0);
		pc_f = stage_addr(1);
		pc_fet = stage_addr(2);
		pc_mux = stage_addr(3);
		pc_dec = stage_addr(4);
		// narrow field ranges so that groups and branch numbers repeat
		for (int n = 0; n < N; n++) begin
			rob[n].v = chance(80);
			rob[n].sn = `STARK_SN_W'(rand_below(64));
			rob[n].grp = 4'(rand_below(4));
			rob[n].bno_t = `STARK_BNO_W'(rand_below(4));
			rob[n].br = chance(30);
			rob[n].cjb = chance(20);
		end
	endtask

	// entered and left on a falling edge
	task automatic run_test(input string name, input int len, input int p_miss,
		input int p_fd, input int p_adv, input int p_fcu);
		test_errors = 0;
		repeat (len) begin
			compare_outputs();
			drive_inputs(p_miss, p_fd, p_adv, p_fcu);
			@(posedge clk);
			model_step();
			@(negedge clk);
		end
		if (test_errors == 0) begin
			$display("test %s: pass (%0d cycles)", name, len);
		end else begin
			tests_failed++;
			$display("test %s: fail (%0d mismatches)", name, test_errors);
		end
	endtask

	initial begin : main
		int total;
		rst = 1'b1;
		advance_pipeline = 1'b0;
		advance_pipeline_seg2 = 1'b0;
		branchmiss = 1'b0;
		found_destination = 1'b0;
		fcu_idv = 1'b0;
		takb = 1'b0;
		missid = '0;
		destination_rndx = '0;
		fcu_id = '0;
		stomp_bno = '0;
		misspc = '0;
		pc = '0;
		pc_f = '0;
		pc_fet = '0;
		pc_mux = '0;
		pc_dec = '0;
		rob = '0;
		repeat (2) begin
			@(posedge clk);
			model_step();
		end
		@(negedge clk);
		rst = 1'b0;

		run_test("reset values", 8, 0, 0, 0, 0);
		run_test("sequencer", 80, 25, 30, 70, 50);
		run_test("waterfall", 120, 8, 0, 50, 50);
		run_test("rob destination", 80, 30, 100, 60, 60);
		run_test("rob miss", 80, 30, 0, 60, 80);
		run_test("mixed traffic", 400, 15, 30, 60, 50);

		total = errors + stark_stomp_inst.branch_sequencer_inst.seq_sva.fail_count +
			stark_stomp_inst.fe_stomp_inst.fe_sva.fail_count;
		$display("summary: 6 tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests_failed, checks, errors, total - errors);
		if (total == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* stark_stomp_sva.sv */
// ============================================================
// concurrent assertions on the sequencer and the waterfall
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module stark_stomp_assertions #(
	// selects the waterfall checks instead of the sequencer checks
	parameter bit WATERFALL = 1'b0
) (
	input wire logic                     clk,
	input wire logic                     rst,
	input wire stark_pkg::branch_state_t branch_state,
	input wire logic                     stomp_pipeline,
	input wire logic                     start,
	input wire logic [4:1]               stomp_r,
	input wire logic [4:0]               stomp
);

	int fail_count = 0;

	if (!WATERFALL) begin : g_seq
		// the recovery walk never stalls
		a_state_moves: assert property (@(posedge clk) disable iff (rst)
			branch_state != stark_pkg::BS_IDLE |=> branch_state != $past(branch_state))
			else begin fail_count++; $error("recovery state stayed put for a cycle"); end

		a_stomp_level: assert property (@(posedge clk) disable iff (rst)
			branch_state != stark_pkg::BS_IDLE |-> stomp_pipeline)
			else begin fail_count++; $error("stomp level low outside idle"); end
	end else begin : g_fe
		// a stage only becomes stomped from the start pulse or from its predecessor
		for (genvar i = 1; i < 5; i++) begin : g_stage
			a_set_cause: assert property (@(posedge clk) disable iff (rst)
				$rose(stomp_r[i]) && !$past(rst) |-> $past(start || stomp[i-1]))
				else begin fail_count++; $error("stage stomp set without a cause"); end
		end
	end

endmodule

bind branch_sequencer stark_stomp_assertions #(.WATERFALL(1'b0)) seq_sva (
	.clk(clk), .rst(rst), .branch_state(branch_state), .stomp_pipeline(stomp_pipeline),
	.start(1'b0), .stomp_r(4'b0), .stomp(5'b0)
);

bind fe_stomp stark_stomp_assertions #(.WATERFALL(1'b1)) fe_sva (
	.clk(clk), .rst(rst), .branch_state(stark_pkg::BS_IDLE), .stomp_pipeline(stomp_pipeline),
	.start(start), .stomp_r(stomp_r), .stomp(stomp)
);

`default_nettype wire

/* stark_stomp.sv */
// ============================================================
// flush subsystem top level
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "stark_cfg.svh"

module stark_stomp (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire logic                          advance_pipeline,
	input  wire logic                          advance_pipeline_seg2,
	input  wire logic                          branchmiss,
	input  wire logic                          found_destination,
	input  wire stark_pkg::rob_ndx_t           destination_rndx,
	input  wire stark_pkg::rob_ndx_t           missid,
	input  wire stark_pkg::pc_address_t        misspc,
	input  wire stark_pkg::pc_address_t        pc,
	input  wire stark_pkg::pc_address_t        pc_f,
	input  wire stark_pkg::pc_address_t        pc_fet,
	input  wire stark_pkg::pc_address_t        pc_mux,
	input  wire stark_pkg::pc_address_t        pc_dec,
	input  wire logic                          fcu_idv,
	input  wire stark_pkg::rob_ndx_t           fcu_id,
	input  wire logic                          takb,
	input  wire logic [`STARK_BNO_W-1:0]       stomp_bno,
	input  wire stark_pkg::rob_array_t         rob,
	output stark_pkg::branch_state_t           branch_state,
	output logic                               stomp_fet,
	output logic                               stomp_mux,
	output logic                               stomp_dec,
	output logic                               stomp_ren,
	output logic [`STARK_ROB_ENTRIES-1:0]      robentry_stomp
);

	// stomp level shared by the front end and the ROB side
	logic stomp_pipeline;

	branch_sequencer branch_sequencer_inst (
		.clk               (clk),
		.rst               (rst),
		.branchmiss        (branchmiss),
		.found_destination (found_destination),
		.branch_state      (branch_state),
		.stomp_pipeline    (stomp_pipeline)
	);

	fe_stomp fe_stomp_inst (
		.clk                   (clk),
		.rst                   (rst),
		.advance_pipeline      (advance_pipeline),
		.advance_pipeline_seg2 (advance_pipeline_seg2),
		.stomp_pipeline        (stomp_pipeline),
		.misspc                (misspc),
		.pc                    (pc),
		.pc_f                  (pc_f),
		.pc_fet                (pc_fet),
		.pc_mux                (pc_mux),
		.pc_dec                (pc_dec),
		.stomp_fet             (stomp_fet),
		.stomp_mux             (stomp_mux),
		.stomp_dec             (stomp_dec),
		.stomp_ren             (stomp_ren)
	);

	rob_stomp rob_stomp_inst (
		.clk               (clk),
		.rst               (rst),
		.rob               (rob),
		.found_destination (found_destination),
		.branchmiss        (branchmiss),
		.fcu_idv           (fcu_idv),
		.takb              (takb),
		.destination_rndx  (destination_rndx),
		.missid            (missid),
		.fcu_id            (fcu_id),
		.stomp_bno         (stomp_bno),
		.branch_state      (branch_state),
		.robentry_stomp    (robentry_stomp)
	);

endmodule

`default_nettype wire

/* rob_stomp.sv */
// ============================================================
// ROB stomp unit
// registered per-entry cancel bitmap after a branch miss
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "stark_cfg.svh"

module rob_stomp (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire stark_pkg::rob_array_t         rob,
	input  wire logic                          found_destination,
	input  wire logic                          branchmiss,
	// the flow control unit holds a resolving branch at fcu_id
	input  wire logic                          fcu_idv,
	input  wire logic                          takb,
	input  wire stark_pkg::rob_ndx_t           destination_rndx,
	input  wire stark_pkg::rob_ndx_t           missid,
	input  wire stark_pkg::rob_ndx_t           fcu_id,
	// branch number that survives the miss
	input  wire logic [`STARK_BNO_W-1:0]       stomp_bno,
	input  wire stark_pkg::branch_state_t      branch_state,
	output logic [`STARK_ROB_ENTRIES-1:0]      robentry_stomp
);

	localparam bit BACKOUT = `STARK_SUPPORT_BACKOUT;

	logic [`STARK_ROB_ENTRIES-1:0] stomp_d;
	logic                          miss_active;
	logic                          exempt_en;
	stark_pkg::rob_entry_t         miss_ent;
	stark_pkg::rob_entry_t         dest_ent;
	stark_pkg::rob_entry_t         fcu_ent;

	assign miss_ent = rob[missid];
	assign dest_ent = rob[destination_rndx];
	assign fcu_ent  = rob[fcu_id];

	// a miss is being worked on until the sequencer reaches its last state
	assign miss_active = branchmiss ||
		(branch_state != stark_pkg::BS_IDLE && branch_state < stark_pkg::BS_DONE2);

	// instructions fetched in the same group behind a resolving branch
	// must stay as copy targets, later groups may depend on their mappings
	assign exempt_en = BACKOUT ?
		(fcu_idv && (fcu_ent.br || fcu_ent.cjb)) :
		(fcu_idv && fcu_ent.br && !takb);

	// ========================================================
	// per-entry decision
	// ========================================================

	always_comb begin
		for (int n = 0; n < `STARK_ROB_ENTRIES; n++) begin
			stomp_d[n] = 1'b0;
			if (found_destination) begin
				// only what sits between the branch and its target goes
				if (rob[n].sn > miss_ent.sn && rob[n].sn < dest_ent.sn)
					stomp_d[n] = 1'b1;
			end else if (miss_active && fcu_idv) begin
				// younger work fetched under another branch number is wrong path
				if (rob[n].sn > miss_ent.sn && rob[n].bno_t != stomp_bno)
					stomp_d[n] = 1'b1;
			end
			if (exempt_en && rob[n].grp == fcu_ent.grp && rob[n].sn > fcu_ent.sn)
				stomp_d[n] = 1'b0;
		end
	end

	// the bitmap fans out widely so it is registered
	always_ff @(posedge clk) begin
		if (rst)
			robentry_stomp <= '0;
		else
			robentry_stomp <= stomp_d;
	end

endmodule

`default_nettype wire

/* fe_stomp.sv */
// ============================================================
// front end stomp waterfall
// miss address delay line and per-stage stomp registers
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "stark_cfg.svh"

module fe_stomp (
	input  wire logic                   clk,
	input  wire logic                   rst,
	// fetch, mux and decode may move
	input  wire logic                   advance_pipeline,
	// rename may move
	input  wire logic                   advance_pipeline_seg2,
	// level from the recovery sequencer
	input  wire logic                   stomp_pipeline,
	// corrected address after the miss
	input  wire stark_pkg::pc_address_t misspc,
	// addresses at the input of align, fetch, mux, decode and rename
	input  wire stark_pkg::pc_address_t pc,
	input  wire stark_pkg::pc_address_t pc_f,
	input  wire stark_pkg::pc_address_t pc_fet,
	input  wire stark_pkg::pc_address_t pc_mux,
	input  wire stark_pkg::pc_address_t pc_dec,
	output logic                        stomp_fet,
	output logic                        stomp_mux,
	output logic                        stomp_dec,
	output logic                        stomp_ren
);

	// miss address the delay line holds out of reset
	localparam stark_pkg::pc_address_t MISS_RST = '{
		bno_t: `STARK_BNO_W'(1),
		bno_f: `STARK_BNO_W'(0),
		pc:    `STARK_PC_W'(`STARK_RSTPC)
	};

	// previous sampled stomp level and the registered rising edge
	logic sp_q;
	logic start;

	// slot n holds the miss address as it should appear at stage n
	stark_pkg::pc_address_t [4:0] slot;

	// stage addresses, index 0 is align and 4 is rename
	stark_pkg::pc_address_t [4:0] stage_pc;

	// advance enable for each registered stage
	logic [4:1] adv;

	// stomp registers for fetch through rename
	logic [4:1] stomp_r;

	// combinational stomp for every stage, align included
	logic [4:0] stomp;

	assign stage_pc = {pc_dec, pc_mux, pc_fet, pc_f, pc};

	// rename sits in the second pipeline segment and has its own advance
	assign adv = {advance_pipeline_seg2, {3{advance_pipeline}}};

	// ========================================================
	// start pulse
	// ========================================================

	// the stomp level is only looked at when the pipe moves, so a
	// stalled front end does not see the edge until it advances
	always_ff @(posedge clk) begin
		if (rst) begin
			sp_q  <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= advance_pipeline && stomp_pipeline && !sp_q;
			if (advance_pipeline)
				sp_q <= stomp_pipeline;
		end
	end

	// ========================================================
	// miss address delay line
	// ========================================================

	// the corrected address walks down the pipe together with the
	// first correct-path group so each stage can recognise it
	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= {5{MISS_RST}};
		end else begin
			if (start)
				slot[0] <= misspc;
			if (start || advance_pipeline)
				slot[4:1] <= slot[3:0];
		end
	end

	// ========================================================
	// stomp waterfall
	// ========================================================

	// align has no register of its own
	// it is only stomped while the start pulse is present
	always_comb begin
		stomp[0] = start && (stage_pc[0].pc != slot[0].pc);
		for (int i = 1; i < 5; i++)
			stomp[i] = (start || stomp_r[i]) && (stage_pc[i].pc != slot[i].pc);
	end

	// every stage starts out stomped and is released once the corrected
	// path shows up there or the stage in front of it is already clean
	// while there is no advance the registers keep their value
	always_ff @(posedge clk) begin
		if (rst) begin
			stomp_r <= '1;
		end else begin
			for (int i = 1; i < 5; i++) begin
				if (start) begin
					stomp_r[i] <= 1'b1;
				end else if (adv[i]) begin
					if (stage_pc[i].pc == slot[i].pc || !stomp[i-1])
						stomp_r[i] <= 1'b0;
					else
						stomp_r[i] <= stomp[i-1];
				end
			end
		end
	end

	assign stomp_fet = stomp[1];
	assign stomp_mux = stomp[2];
	assign stomp_dec = stomp[3];
	assign stomp_ren = stomp[4];

endmodule

`default_nettype wire

/* branch_sequencer.sv */
// ============================================================
// branch recovery sequencer
// steps through the recovery states after an unresolved miss
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "stark_cfg.svh"

module branch_sequencer (
	input  wire logic                      clk,
	input  wire logic                      rst,
	// one cycle strobe from the branch unit
	input  wire logic                      branchmiss,
	// the miss target is already queued in the ROB
	input  wire logic                      found_destination,
	output stark_pkg::branch_state_t       branch_state,
	output logic                           stomp_pipeline
);

	stark_pkg::branch_state_t next_state;

	// ========================================================
	// next state
	// ========================================================

	// a miss whose target is already in the ROB needs no front end
	// recovery, the ROB stomp unit cancels the entries in between
	always_comb begin
		next_state = branch_state;
		case (branch_state)
			stark_pkg::BS_IDLE: begin
				if (branchmiss && !found_destination)
					next_state = stark_pkg::BS_CHKPT_RESTORE;
			end
			// the walk below ignores further misses, the first one wins
			stark_pkg::BS_CHKPT_RESTORE:
				next_state = stark_pkg::BS_CAPTURE_MISSPC;
			stark_pkg::BS_CAPTURE_MISSPC:
				next_state = stark_pkg::BS_DONE;
			stark_pkg::BS_DONE:
				next_state = stark_pkg::BS_DONE2;
			stark_pkg::BS_DONE2:
				next_state = stark_pkg::BS_IDLE;
			// unused codes fall back to idle
			default:
				next_state = stark_pkg::BS_IDLE;
		endcase
	end

	// ========================================================
	// state register
	// ========================================================

	always_ff @(posedge clk) begin
		if (rst)
			branch_state <= stark_pkg::BS_IDLE;
		else
			branch_state <= next_state;
	end

	// the front end is told to stomp in the miss cycle itself and for
	// as long as the sequence is running
	always_comb begin
		stomp_pipeline =
			(branchmiss && !found_destination) ||
			(branch_state >= stark_pkg::BS_CHKPT_RESTORE &&
			 branch_state <= stark_pkg::BS_DONE2);
	end

endmodule

`default_nettype wire

/* stark_pkg.sv */
// ============================================================
// shared types for the flush subsystem
// addresses, ROB entries and the recovery state encoding
// ============================================================

`default_nettype none

`include "stark_cfg.svh"

package stark_pkg;

	// an instruction address tagged with its branch numbers
	// bno_t is the number on the taken side, bno_f on the fall-through
	typedef struct packed {
		logic [`STARK_BNO_W-1:0] bno_t;
		logic [`STARK_BNO_W-1:0] bno_f;
		logic [`STARK_PC_W-1:0]  pc;
	} pc_address_t;

	// an index into the re-order buffer
	typedef logic [$clog2(`STARK_ROB_ENTRIES)-1:0] rob_ndx_t;

	// the part of a ROB entry the stomp logic looks at
	typedef struct packed {
		// entry holds an instruction
		logic                    v;
		// sequence number, larger is younger
		logic [`STARK_SN_W-1:0]  sn;
		// tag shared by all instructions fetched in one group
		logic [3:0]              grp;
		// branch number the instruction was fetched under
		logic [`STARK_BNO_W-1:0] bno_t;
		// conditional branch
		logic                    br;
		// call or jump
		logic                    cjb;
	} rob_entry_t;

	// the whole buffer moves as one packed array
	typedef rob_entry_t [`STARK_ROB_ENTRIES-1:0] rob_array_t;

	// branch recovery states
	// the order matters since the stomp logic tests state ranges
	typedef enum logic [2:0] {
		BS_IDLE           = 3'd0,
		BS_CHKPT_RESTORE  = 3'd1,
		BS_CAPTURE_MISSPC = 3'd2,
		BS_DONE           = 3'd3,
		BS_DONE2          = 3'd4
	} branch_state_t;

endpackage

`default_nettype wire

/* stark_cfg.svh */
// ============================================================
// configuration macros for the flush subsystem
// ROB size, field widths, reset miss address, backout option
// ============================================================

`ifndef STARK_CFG_SVH
`define STARK_CFG_SVH

// number of re-order buffer entries, a power of two
`define STARK_ROB_ENTRIES 8

// width of the ROB sequence number used for age compares
`define STARK_SN_W 6

// program counter width
`define STARK_PC_W 32

// width of the branch number carried with each address
`define STARK_BNO_W 5

// when set, instructions grouped behind any resolving branch or call
// become copy targets; when clear only a not-taken conditional does
`define STARK_SUPPORT_BACKOUT 1

// miss address the delay line holds coming out of reset
// sized for a 32 bit PC
`define STARK_RSTPC 32'hfffc0100

`endif
